// File: game_ctrl.sv
// game controller, tick generation plus mode and heading FSM issuing moves
`timescale 1ns/100ps
`default_nettype none

module game_ctrl import snake_pkg::*; #(
    parameter int TICK_CYCLES = DEF_TICK_CYCLES
) (
    input  wire logic main_clk,
    input  wire logic rst_n,
    input  wire logic cmd_valid,
    input  wire cmd_t cmd,
    output logic      all_black,
    move_if.ctrl      mv
);

    localparam int CNT_W = (TICK_CYCLES > 1) ? $clog2(TICK_CYCLES) : 1;

    typedef enum logic [1:0] {
        mode_wait,
        mode_run,
        mode_pause,
        mode_black
    } mode_t;

    mode_t            mode;
    logic [CNT_W-1:0] tick_cnt;
    logic             tick;
    logic             pend_valid;
    cmd_t             pend_cmd;
    logic             cur_valid;
    cmd_t             cur_cmd;
    logic             is_arrow;
    dir_t             arrow_dir;
    logic             turn_ok;

    assign tick = (tick_cnt == CNT_W'(TICK_CYCLES - 1));

    // a strobe on the tick itself wins over the held one
    assign cur_valid = cmd_valid | pend_valid;
    assign cur_cmd   = cmd_valid ? cmd : pend_cmd;

    always_comb begin
        is_arrow  = cur_valid;
        arrow_dir = dir_right;
        case (cur_cmd)
            cmd_up:    arrow_dir = dir_up;
            cmd_down:  arrow_dir = dir_down;
            cmd_left:  arrow_dir = dir_left;
            cmd_right: arrow_dir = dir_right;
            default:   is_arrow = 1'b0;
        endcase
    end

    // only a quarter turn, never along the current axis
    assign turn_ok = is_arrow &&
        ((arrow_dir inside {dir_up, dir_down}) != (mv.heading inside {dir_up, dir_down}));

    always_ff @(posedge main_clk or negedge rst_n) begin
        if (!rst_n) begin
            tick_cnt   <= '0;
            pend_valid <= 1'b0;
            pend_cmd   <= cmd_start;
        end else begin
            tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
            if (tick)
                pend_valid <= 1'b0; // consumed
            else if (cmd_valid) begin
                pend_valid <= 1'b1;
                pend_cmd   <= cmd;
            end
        end
    end

    always_ff @(posedge main_clk or negedge rst_n) begin
        if (!rst_n) begin
            mode         <= mode_wait;
            all_black    <= 1'b0;
            mv.heading   <= dir_right;
            mv.step      <= 1'b0;
            mv.load_init <= 1'b0;
            mv.load_wait <= 1'b0;
        end else begin
            mv.step      <= 1'b0;
            mv.load_init <= 1'b0;
            mv.load_wait <= 1'b0;
            if (tick) begin
                if (cur_valid && cur_cmd == cmd_esc) begin
                    mode      <= mode_black;
                    all_black <= 1'b1;
                end else if (cur_valid && cur_cmd == cmd_start) begin
                    mode         <= mode_run;
                    all_black    <= 1'b0;
                    mv.heading   <= dir_right;
                    mv.load_init <= 1'b1;
                end else begin
                    case (mode)
                        mode_run: begin
                            if (cur_valid && cur_cmd == cmd_pause) begin
                                mode <= mode_pause;
                            end else begin
                                if (turn_ok)
                                    mv.heading <= arrow_dir;
                                mv.step <= 1'b1;
                            end
                        end
                        mode_pause: begin
                            if (cur_valid && cur_cmd == cmd_resume) begin
                                mode    <= mode_run;
                                mv.step <= 1'b1; // moves on the resume tick
                            end
                        end
                        mode_wait: mv.load_wait <= 1'b1; // keep the idle picture
                        default: ;
                    endcase
                end
            end
        end
    end

    // orders only ever follow a tick, and never a move with a rebuild
    a_order_excl: assert property (
        @(posedge main_clk) disable iff (!rst_n)
        (mv.step || mv.load_init) |-> !(mv.step && mv.load_init) && $past(tick)
    );

endmodule

`default_nettype wire

// File: key_decoder.sv
// scan code decoder, turns received bytes into one-cycle game commands
`timescale 1ns/100ps
`default_nettype none

module key_decoder import snake_pkg::*; (
    input  wire logic       main_clk,
    input  wire logic       rst_n,
    input  wire logic [7:0] byte_data,
    input  wire logic       byte_valid,
    output logic            cmd_valid,
    output cmd_t            cmd
);

    logic break_flag; // last byte was the release prefix
    logic dec_hit;
    cmd_t dec_cmd;

    always_comb begin
        dec_hit = 1'b1;
        dec_cmd = cmd_start;
        case (byte_data)
            key_start:  dec_cmd = cmd_start;
            key_esc:    dec_cmd = cmd_esc;
            key_pause:  dec_cmd = cmd_pause;
            key_resume: dec_cmd = cmd_resume;
            key_up:     dec_cmd = cmd_up;
            key_down:   dec_cmd = cmd_down;
            key_left:   dec_cmd = cmd_left;
            key_right:  dec_cmd = cmd_right;
            default:    dec_hit = 1'b0; // unknown or prefix byte
        endcase
    end

    always_ff @(posedge main_clk or negedge rst_n) begin
        if (!rst_n) begin
            break_flag <= 1'b0;
            cmd_valid  <= 1'b0;
        end else begin
            cmd_valid <= 1'b0;
            if (byte_valid) begin
                if (break_flag)
                    break_flag <= 1'b0; // released key is swallowed
                else if (byte_data == key_break)
                    break_flag <= 1'b1;
                else
                    cmd_valid <= dec_hit;
            end
        end
    end

    always_ff @(posedge main_clk) begin
        if (byte_valid)
            cmd <= dec_cmd;
    end

endmodule

`default_nettype wire

// File: move_if.sv
// movement orders from the game controller to the body ring
`timescale 1ns/100ps
`default_nettype none

interface move_if import snake_pkg::*; ();

    logic step;      // advance one segment
    dir_t heading;
    logic load_init; // rebuild at start row
    logic load_wait; // rebuild at waiting row

    modport ctrl (
        output step, heading, load_init, load_wait
    );

    modport body (
        input step, heading, load_init, load_wait
    );

endinterface

`default_nettype wire

// File: ps2_rx.sv
// PS/2 receiver, synchronizes the keyboard lines and emits parity-checked bytes
`timescale 1ns/100ps
`default_nettype none

module ps2_rx (
    input  wire logic       main_clk,
    input  wire logic       rst_n,
    input  wire logic       ps2_clk,
    input  wire logic       ps2_data,
    output logic [7:0]      byte_data,
    output logic            byte_valid
);

    logic [1:0]  clk_sync;
    logic [1:0]  data_sync;
    logic        clk_prev;
    logic        fall_q;     // registered falling edge
    logic        bit_q;      // data bit taken at that edge
    logic [3:0]  bit_cnt;
    logic        frame_done;
    logic [10:0] frame;

    always_ff @(posedge main_clk or negedge rst_n) begin
        if (!rst_n) begin
            clk_sync   <= 2'b11; // idle lines are high
            data_sync  <= 2'b11;
            clk_prev   <= 1'b1;
            fall_q     <= 1'b0;
            bit_cnt    <= 4'd0;
            frame_done <= 1'b0;
            byte_valid <= 1'b0;
        end else begin
            clk_sync   <= {clk_sync[0], ps2_clk};
            data_sync  <= {data_sync[0], ps2_data};
            clk_prev   <= clk_sync[1];
            fall_q     <= clk_prev & ~clk_sync[1];
            frame_done <= 1'b0;
            if (fall_q) begin
                if (bit_cnt == 4'd10) begin
                    bit_cnt    <= 4'd0;
                    frame_done <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
            // start low, stop high, data plus parity odd
            byte_valid <= frame_done & ~frame[0] & frame[10] & (^frame[9:1]);
        end
    end

    always_ff @(posedge main_clk) begin
        bit_q <= data_sync[1];
        if (fall_q)
            frame <= {bit_q, frame[10:1]}; // lsb arrives first
        if (frame_done)
            byte_data <= frame[8:1];
    end

    a_valid_single: assert property (
        @(posedge main_clk) disable iff (!rst_n)
        byte_valid |=> !byte_valid
    );

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# compile and run the snake engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_snake -f tb.f -o tb_snake_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build stopped with status $status"
    exit "$status"
fi

./obj_dir/tb_snake_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation ended with status $status"
    exit "$status"
fi
exit 0

// File: snake_body.sv
// snake body ring, head and tail pointers with head-first coordinate outputs
`timescale 1ns/100ps
`default_nettype none

module snake_body import snake_pkg::*; #(
    parameter int     SNAKE_LEN = DEF_SNAKE_LEN,
    parameter coord_t INIT_ROW  = DEF_INIT_ROW,
    parameter coord_t WAIT_ROW  = DEF_WAIT_ROW
) (
    input  wire logic               main_clk,
    input  wire logic               rst_n,
    move_if.body                    mv,
    output coord_t [SNAKE_LEN-1:0]  body_x,
    output coord_t [SNAKE_LEN-1:0]  body_y
);

    localparam int PTR_W = (SNAKE_LEN > 1) ? $clog2(SNAKE_LEN) : 1;
    localparam logic [PTR_W-1:0] LAST = PTR_W'(SNAKE_LEN - 1);

    coord_t           ring_x [SNAKE_LEN];
    coord_t           ring_y [SNAKE_LEN];
    logic [PTR_W-1:0] head_ptr;
    logic [PTR_W-1:0] tail_ptr;
    coord_t           next_x;
    coord_t           next_y;
    coord_t           load_row;

    assign load_row = mv.load_init ? INIT_ROW : WAIT_ROW;

    always_comb begin
        next_x = ring_x[head_ptr];
        next_y = ring_y[head_ptr];
        case (mv.heading)
            dir_up:    next_y = ring_y[head_ptr] - 7'd1; // screen y grows downward
            dir_down:  next_y = ring_y[head_ptr] + 7'd1;
            dir_left:  next_x = ring_x[head_ptr] - 7'd1;
            default:   next_x = ring_x[head_ptr] + 7'd1;
        endcase
    end

    always_ff @(posedge main_clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < SNAKE_LEN; k++) begin
                ring_x[k] <= coord_t'(k);
                ring_y[k] <= WAIT_ROW;
            end
            head_ptr <= LAST;
            tail_ptr <= '0;
        end else if (mv.load_init || mv.load_wait) begin
            for (int k = 0; k < SNAKE_LEN; k++) begin
                ring_x[k] <= coord_t'(k);
                ring_y[k] <= load_row;
            end
            head_ptr <= LAST;
            tail_ptr <= '0;
        end else if (mv.step) begin
            ring_x[tail_ptr] <= next_x; // tail slot becomes new head
            ring_y[tail_ptr] <= next_y;
            head_ptr         <= tail_ptr;
            tail_ptr         <= (tail_ptr == LAST) ? '0 : tail_ptr + 1'b1;
        end
    end

    // index 0 is the head, walking back toward the tail
    always_comb begin
        int idx;
        for (int i = 0; i < SNAKE_LEN; i++) begin
            idx = int'(head_ptr) - i;
            if (idx < 0)
                idx = idx + SNAKE_LEN;
            body_x[i] = ring_x[idx];
            body_y[i] = ring_y[idx];
        end
    end

    a_step_vs_init: assert property (
        @(posedge main_clk) disable iff (!rst_n)
        !(mv.step && mv.load_init)
    );

endmodule

`default_nettype wire

// File: snake_input.txt
# key <scan code hex> <bad parity 0/1> | ticks <count> | expect <head x> <head y> <all_black>
# keys go out right after a tick boundary, expect is checked 2 cycles after the last tick
ticks 1
expect 3 48 0
ticks 2
expect 3 48 0
key 1b 0      # start
ticks 1
expect 3 23 0
ticks 1
expect 4 23 0
ticks 1
expect 5 23 0
key 6b 0      # left while heading right is a reverse
ticks 1
expect 6 23 0
key 75 0      # up
ticks 1
expect 6 22 0
key 6b 0      # left
ticks 1
expect 5 22 0
key 72 0      # down
ticks 1
expect 5 23 0
key f0 0      # release prefix
ticks 1
expect 5 24 0
key 74 0      # right after the prefix is swallowed
ticks 1
expect 5 25 0
key 4d 0      # pause
ticks 1
expect 5 25 0
ticks 3
expect 5 25 0
key 2d 0      # resume moves on the same tick
ticks 1
expect 5 26 0
key 76 0      # esc
ticks 1
expect 5 26 1
key 6b 0      # arrows do nothing while blanked
ticks 2
expect 5 26 1
key 1b 0      # start again
ticks 1
expect 3 23 0
key 75 1      # up with wrong parity is dropped
ticks 1
expect 4 23 0
ticks 1
expect 5 23 0

// File: snake_pkg.sv
// snake game shared types, keyboard scan codes and default sizes
`default_nettype none

package snake_pkg;

    typedef logic [6:0] coord_t; // one screen coordinate, wraps at 128

    typedef enum logic [3:0] {
        cmd_start,
        cmd_esc,
        cmd_pause,
        cmd_resume,
        cmd_up,
        cmd_down,
        cmd_left,
        cmd_right
    } cmd_t;

    typedef enum logic [1:0] {
        dir_up,
        dir_down,
        dir_left,
        dir_right
    } dir_t;

    // set 2 scan codes
    localparam logic [7:0] key_start  = 8'h1B;
    localparam logic [7:0] key_esc    = 8'h76;
    localparam logic [7:0] key_pause  = 8'h4D;
    localparam logic [7:0] key_resume = 8'h2D;
    localparam logic [7:0] key_up     = 8'h75;
    localparam logic [7:0] key_down   = 8'h72;
    localparam logic [7:0] key_left   = 8'h6B;
    localparam logic [7:0] key_right  = 8'h74;
    localparam logic [7:0] key_break  = 8'hF0; // release prefix

    localparam int     DEF_SNAKE_LEN   = 4;
    localparam coord_t DEF_WAIT_ROW    = 7'd48;
    localparam coord_t DEF_INIT_ROW    = 7'd23;
    localparam int     DEF_TICK_CYCLES = 10_000_000; // about 10 Hz at 100 MHz

endpackage

`default_nettype wire

// File: snake_top.sv
// snake position engine top, keyboard input to controller to body ring
`timescale 1ns/100ps
`default_nettype none

module snake_top import snake_pkg::*; #(
    parameter int     SNAKE_LEN   = DEF_SNAKE_LEN,
    parameter coord_t INIT_ROW    = DEF_INIT_ROW,
    parameter coord_t WAIT_ROW    = DEF_WAIT_ROW,
    parameter int     TICK_CYCLES = DEF_TICK_CYCLES
) (
    input  wire logic               main_clk,
    input  wire logic               rst_n,
    input  wire logic               ps2_clk,
    input  wire logic               ps2_data,
    output coord_t [SNAKE_LEN-1:0]  body_x,
    output coord_t [SNAKE_LEN-1:0]  body_y,
    output logic                    all_black
);

    logic [7:0] byte_data;
    logic       byte_valid;
    logic       cmd_valid;
    cmd_t       cmd;

    move_if mv_if ();

    ps2_rx u_ps2_rx (
        .main_clk   (main_clk),
        .rst_n      (rst_n),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .byte_data  (byte_data),
        .byte_valid (byte_valid)
    );

    key_decoder u_key_decoder (
        .main_clk   (main_clk),
        .rst_n      (rst_n),
        .byte_data  (byte_data),
        .byte_valid (byte_valid),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd)
    );

    game_ctrl #(
        .TICK_CYCLES (TICK_CYCLES)
    ) u_game_ctrl (
        .main_clk  (main_clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .all_black (all_black),
        .mv        (mv_if.ctrl)
    );

    snake_body #(
        .SNAKE_LEN (SNAKE_LEN),
        .INIT_ROW  (INIT_ROW),
        .WAIT_ROW  (WAIT_ROW)
    ) u_snake_body (
        .main_clk (main_clk),
        .rst_n    (rst_n),
        .mv       (mv_if.body),
        .body_x   (body_x),
        .body_y   (body_y)
    );

endmodule

`default_nettype wire

// File: tb.f
snake_pkg.sv
move_if.sv
ps2_rx.sv
key_decoder.sv
game_ctrl.sv
snake_body.sv
snake_top.sv
tb_snake.sv

// File: tb_snake.sv
// testbench for the snake engine that sends PS/2 keys from a script and checks body and blank outputs
`timescale 1ns/100ps
`default_nettype none

module tb_snake import snake_pkg::*; ();

    localparam int     SNAKE_LEN   = 4;
    localparam coord_t INIT_ROW    = 7'd23;
    localparam coord_t WAIT_ROW    = 7'd48;
    localparam int     TICK_CYCLES = 128;

    logic                   main_clk;
    logic                   rst_n;
    logic                   ps2_clk;
    logic                   ps2_data;
    coord_t [SNAKE_LEN-1:0] body_x;
    coord_t [SNAKE_LEN-1:0] body_y;
    logic                   all_black;

    int     cyc = 0;       // cycles since reset release
    int     cyc_limit = 0; // zero until the script is loaded
    int     op_kind[$];    // 0 key, 1 ticks, 2 expect
    int     op_a[$];
    int     op_b[$];
    int     op_c[$];
    int     op_line[$];
    int     ticks_since = 0;
    bit     body_known = 0;
    coord_t exp_x[SNAKE_LEN]; // expected body, head first
    coord_t exp_y[SNAKE_LEN];

    snake_top #(
        .SNAKE_LEN   (SNAKE_LEN),
        .INIT_ROW    (INIT_ROW),
        .WAIT_ROW    (WAIT_ROW),
        .TICK_CYCLES (TICK_CYCLES)
    ) dut0 (
        .main_clk  (main_clk),
        .rst_n     (rst_n),
        .ps2_clk   (ps2_clk),
        .ps2_data  (ps2_data),
        .body_x    (body_x),
        .body_y    (body_y),
        .all_black (all_black)
    );

    initial begin
        main_clk = 1'b0;
        forever #4 main_clk = ~main_clk;
    end

    always @(posedge main_clk) begin
        if (rst_n)
            cyc <= cyc + 1;
        if (cyc_limit > 0 && cyc >= cyc_limit) begin
            $display("sim failed");
            $fatal(1, "timeout, the run went past %0d cycles without finishing", cyc_limit);
        end
    end

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("Mismatch %s: expected %0d, actual %0d", name, expected, actual);
            $display("sim failed");
            $fatal(1, "output check failed");
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge main_clk);
            #1;
        end
    endtask

    // waits for the next game tick boundary counted from reset release
    task automatic wait_tick();
        do begin
            @(posedge main_clk);
            #1;
        end while (cyc % TICK_CYCLES != 0);
    endtask

    function automatic bit unit_step(input coord_t px, input coord_t py,
                                     input coord_t x, input coord_t y);
        coord_t dx;
        coord_t dy;
        dx = x - px;
        dy = y - py;
        return (dy == 7'd0 && (dx == 7'd1 || dx == 7'd127)) ||
               (dx == 7'd0 && (dy == 7'd1 || dy == 7'd127));
    endfunction

    // start, 8 data bits lsb first, odd parity, stop
    task automatic send_frame(input logic [7:0] code, input bit bad_parity);
        logic [10:0] bits;
        int          gap;
        gap  = $urandom % 4;
        bits = {1'b1, (~^code) ^ bad_parity, code, 1'b0};
        wait_cycles(gap);
        for (int i = 0; i < 11; i++) begin
            ps2_data = bits[i];
            wait_cycles(4);
            ps2_clk = 1'b0;
            wait_cycles(4);
            ps2_clk = 1'b1;
        end
        wait_cycles(4);
        ps2_data = 1'b1;
    endtask

    task automatic load_script();
        int          fd;
        int          ln;
        int          cnt;
        int          need;
        int          a;
        int          b;
        int          c;
        int          tick_sum;
        int          key_cnt;
        string       line;
        logic [63:0] word;
        ln = 0;
        tick_sum = 0;
        key_cnt = 0;
        fd = $fopen("snake_input.txt", "r");
        if (fd == 0) begin
            $display("sim failed");
            $fatal(1, "could not open the stimulus file snake_input.txt");
        end
        while ($fgets(line, fd) != 0) begin
            ln++;
            if (line.len() < 2 || line[0] == "#")
                continue;
            a = 0;
            b = 0;
            c = 0;
            cnt = $sscanf(line, "%s", word);
            if (word == "key") begin
                need = 3;
                cnt = $sscanf(line, "%s %h %d", word, a, b);
                op_kind.push_back(0);
                key_cnt++;
            end else if (word == "ticks") begin
                need = 2;
                cnt = $sscanf(line, "%s %d", word, a);
                op_kind.push_back(1);
                tick_sum += a;
            end else if (word == "expect") begin
                need = 4;
                cnt = $sscanf(line, "%s %d %d %d", word, a, b, c);
                op_kind.push_back(2);
            end else begin
                need = 99; // unknown line kind
            end
            if (cnt < need) begin
                $display("sim failed");
                $fatal(1, "stimulus file line %0d could not be understood", ln);
            end
            op_a.push_back(a);
            op_b.push_back(b);
            op_c.push_back(c);
            op_line.push_back(ln);
        end
        $fclose(fd);
        cyc_limit = 2 * (tick_sum + key_cnt + 4) * TICK_CYCLES;
    endtask

    task automatic check_head(input int n);
        string  tag;
        coord_t hx;
        coord_t hy;
        bit     frozen;
        wait_cycles(2); // order register plus body update
        tag = $sformatf("line %0d", op_line[n]);
        hx  = coord_t'(op_a[n]);
        hy  = coord_t'(op_b[n]);
        check_value({tag, " head x"}, op_a[n], int'(body_x[0]));
        check_value({tag, " head y"}, op_b[n], int'(body_y[0]));
        check_value({tag, " all_black"}, op_c[n], int'(all_black));
        frozen = body_known && hx == exp_x[0] && hy == exp_y[0];
        if (!frozen && hx == coord_t'(SNAKE_LEN - 1) &&
                (hy == INIT_ROW || hy == WAIT_ROW)) begin
            // rebuilt straight row with the head at the right end
            for (int i = 0; i < SNAKE_LEN; i++) begin
                exp_x[i] = coord_t'(SNAKE_LEN - 1 - i);
                exp_y[i] = hy;
            end
            body_known = 1'b1;
        end else if (!frozen && body_known && ticks_since == 1 &&
                unit_step(exp_x[0], exp_y[0], hx, hy)) begin
            // each segment takes the place of the one ahead
            for (int i = SNAKE_LEN - 1; i > 0; i--) begin
                exp_x[i] = exp_x[i-1];
                exp_y[i] = exp_y[i-1];
            end
            exp_x[0] = hx;
            exp_y[0] = hy;
        end else if (!frozen) begin
            body_known = 1'b0; // more than one step, body not tracked
        end
        if (body_known) begin
            for (int i = 1; i < SNAKE_LEN; i++) begin
                check_value($sformatf("%s segment %0d x", tag, i),
                            int'(exp_x[i]), int'(body_x[i]));
                check_value($sformatf("%s segment %0d y", tag, i),
                            int'(exp_y[i]), int'(body_y[i]));
            end
        end
        ticks_since = 0;
    endtask

    initial begin
        rst_n    = 1'b0;
        ps2_clk  = 1'b1;
        ps2_data = 1'b1;
        void'($urandom(55));
        load_script();
        repeat (3) @(posedge main_clk);
        #1 rst_n = 1'b1;
        for (int n = 0; n < op_kind.size(); n++) begin
            case (op_kind[n])
                0: send_frame(8'(op_a[n]), op_b[n] != 0);
                1: begin
                    repeat (op_a[n]) wait_tick();
                    ticks_since += op_a[n];
                end
                default: check_head(n);
            endcase
        end
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire
